//--- common/rle_stream_settings.svh
// Width, depth and run length settings for the run-length compression subsystem
`ifndef RLE_STREAM_SETTINGS_SVH
`define RLE_STREAM_SETTINGS_SVH

// Data byte and run field widths
`define RLE_BYTE_W 8
`define RLE_RUN_W 8

// Longest run carried by a single output pair
`define RLE_RUN_MAX 8

// FIFO array depths without the extra output tap word
`define RLE_IN_DEPTH 4
`define RLE_OUT_DEPTH 4

`endif

//--- common/rle_stream_pkg.sv
// Encoder state enum and input and output FIFO word layouts
`include "rle_stream_settings.svh"

package rle_stream_pkg;

    // Encoder FSM states
    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_RUN,
        ENC_EMIT
    } enc_state_t;

    // One input FIFO word holding a byte and its end of stream marker
    typedef struct packed {
        logic                   last;
        logic [`RLE_BYTE_W-1:0] data;
    } in_word_t;

    // One output FIFO word holding a run length and byte pair
    typedef struct packed {
        logic                   last;
        logic [`RLE_RUN_W-1:0]  run;
        logic [`RLE_BYTE_W-1:0] data;
    } out_word_t;

endpackage

//--- fifo/common_fifo.sv
// First-word-fall-through FIFO with circular array, occupancy count and output tap
`timescale 1ns/10ps

module common_fifo #(
    parameter int DEPTH = 4,
    parameter int DSIZE = 8
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic [DSIZE-1:0]                   wdata,
    input  logic                               wr_en,
    input  logic                               rd_en,
    output logic [DSIZE-1:0]                   rdata,
    output logic [$clog2(DEPTH+1)-1:0]         count,
    output logic                               empty,
    output logic                               full
);

    localparam int PSIZE = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CSIZE = $clog2(DEPTH + 1);

    logic [DSIZE-1:0] data_array [DEPTH];
    logic [PSIZE-1:0] wpoint;
    logic [PSIZE-1:0] rpoint;
    logic [CSIZE-1:0] count_next;
    logic             data_array_empty;
    logic             tap_vld;
    logic             tap_req;
    logic             tap_load;
    logic             wr_acc;
    logic             rd_acc;

    // Writes are dropped while the array is full
    assign wr_acc = wr_en && !full;

    // Pops only count while the tap holds a word
    assign rd_acc = rd_en && tap_vld;

    // Tap asks for a word when idle or being popped
    assign tap_req  = !tap_vld || rd_acc;
    assign tap_load = tap_req && !data_array_empty;

    // Write pointer
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wpoint <= '0;
        end else if (wr_acc) begin
            if (wpoint == PSIZE'(DEPTH - 1)) begin
                wpoint <= '0;
            end else begin
                wpoint <= wpoint + 1'b1;
            end
        end
    end

    // Read pointer moves when the tap takes a word from the array
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rpoint <= '0;
        end else if (tap_load) begin
            if (rpoint == PSIZE'(DEPTH - 1)) begin
                rpoint <= '0;
            end else begin
                rpoint <= rpoint + 1'b1;
            end
        end
    end

    // Words held in the array without the tap word
    always_comb begin
        case ({wr_acc, tap_load})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // Registered array flags derived from the next occupancy
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            full             <= 1'b0;
            data_array_empty <= 1'b1;
        end else begin
            full             <= (count_next == CSIZE'(DEPTH));
            data_array_empty <= (count_next == '0);
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (wr_acc) begin
            data_array[wpoint] <= wdata;
        end
    end

    // Output tap register refilled on the same edge as a pop
    always_ff @(posedge clock) begin
        if (tap_load) begin
            rdata <= data_array[rpoint];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tap_vld <= 1'b0;
        end else if (tap_load) begin
            tap_vld <= 1'b1;
        end else if (rd_acc) begin
            // Popped with nothing behind it
            tap_vld <= 1'b0;
        end
    end

    // Head word is visible whenever the tap is loaded
    assign empty = !tap_vld;

endmodule

//--- logic/run_length_encoder.sv
// Run-length encoder FSM between the input byte FIFO and the output pair FIFO
`timescale 1ns/10ps
`include "rle_stream_settings.svh"

module run_length_encoder (
    input  logic                     clock,
    input  logic                     rst_n,
    input  rle_stream_pkg::in_word_t in_head,
    input  logic                     in_empty,
    input  logic                     out_full,
    output logic                     in_pop,
    output logic                     out_push,
    output rle_stream_pkg::out_word_t out_word
);

    import rle_stream_pkg::*;

    enc_state_t             state;
    enc_state_t             next_state;
    logic [`RLE_BYTE_W-1:0] cur_byte;
    logic [`RLE_RUN_W-1:0]  run_cnt;
    logic                   pend_last;
    logic                   run_full;
    logic                   same_byte;
    logic                   run_close;

    assign run_full  = (run_cnt >= `RLE_RUN_W'(`RLE_RUN_MAX));
    assign same_byte = (in_head.data == cur_byte);

    // Run ends on a last byte, a full run, or a different byte at the head
    assign run_close = pend_last || run_full || (!in_empty && !same_byte);

    // Pop and push decisions
    always_comb begin
        in_pop     = 1'b0;
        out_push   = 1'b0;
        next_state = state;
        case (state)
            ENC_IDLE: begin
                in_pop = !in_empty;
                if (!in_empty) begin
                    next_state = ENC_RUN;
                end
            end
            ENC_RUN: begin
                // Extend the run, otherwise wait for input or close it
                in_pop = !in_empty && same_byte && !pend_last && !run_full;
                if (run_close) begin
                    next_state = ENC_EMIT;
                end
            end
            ENC_EMIT: begin
                out_push = !out_full;
                if (!out_full) begin
                    next_state = ENC_IDLE;
                end
            end
            default: begin
                next_state = ENC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Run contents loaded fresh at the start of every run
    always_ff @(posedge clock) begin
        if (in_pop) begin
            pend_last <= in_head.last;
            if (state == ENC_IDLE) begin
                cur_byte <= in_head.data;
                run_cnt  <= `RLE_RUN_W'(1);
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

    // Pair presented straight from the run registers
    assign out_word.last = pend_last;
    assign out_word.run  = run_cnt;
    assign out_word.data = cur_byte;

endmodule

//--- logic/rle_stream_top.sv
// Top level with input FIFO, run-length encoder and output FIFO
`timescale 1ns/10ps
`include "rle_stream_settings.svh"

module rle_stream_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [`RLE_BYTE_W-1:0] in_data,
    input  logic                   in_last,
    input  logic                   out_rd,
    output logic                   in_full,
    output logic [`RLE_RUN_W-1:0]  out_run,
    output logic [`RLE_BYTE_W-1:0] out_byte,
    output logic                   out_last,
    output logic                   out_empty
);

    import rle_stream_pkg::*;

    in_word_t  in_wr_word;
    in_word_t  in_head;
    out_word_t out_word;
    out_word_t out_head;
    logic      in_empty;
    logic      in_pop;
    logic      out_push;
    logic      out_full;

    assign in_wr_word.last = in_last;
    assign in_wr_word.data = in_data;

    common_fifo #(
        .DEPTH (`RLE_IN_DEPTH),
        .DSIZE ($bits(in_word_t))
    ) u_in_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .wdata (in_wr_word),
        .wr_en (in_valid),
        .rd_en (in_pop),
        .rdata (in_head),
        .count (),
        .empty (in_empty),
        .full  (in_full)
    );

    run_length_encoder u_encoder (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_head  (in_head),
        .in_empty (in_empty),
        .out_full (out_full),
        .in_pop   (in_pop),
        .out_push (out_push),
        .out_word (out_word)
    );

    common_fifo #(
        .DEPTH (`RLE_OUT_DEPTH),
        .DSIZE ($bits(out_word_t))
    ) u_out_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .wdata (out_word),
        .wr_en (out_push),
        .rd_en (out_rd),
        .rdata (out_head),
        .count (),
        .empty (out_empty),
        .full  (out_full)
    );

    // Split the head pair into its fields
    assign out_run  = out_head.run;
    assign out_byte = out_head.data;
    assign out_last = out_head.last;

endmodule

//--- tb/rle_stream_assert.sv
// Concurrent assertions on the run-length encoder pop and push rules, with bind
`timescale 1ns/10ps
`include "rle_stream_settings.svh"

module rle_stream_assert (
    input logic                      clock,
    input logic                      rst_n,
    input rle_stream_pkg::enc_state_t state,
    input logic                      in_empty,
    input logic                      in_pop,
    input logic                      out_full,
    input logic                      out_push,
    input rle_stream_pkg::out_word_t out_word
);

    import rle_stream_pkg::*;

    // Pairs leave only from the emit state and only into a FIFO with room
    push_with_room: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_push |-> (!out_full && state == ENC_EMIT)
    ) else $error("out_push while out_full is high or outside ENC_EMIT");

    pop_with_data: assert property (
        @(posedge clock) disable iff (!rst_n)
        in_pop |-> !in_empty
    ) else $error("in_pop while in_empty is high");

    // Run field range
    run_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_push |-> (out_word.run >= `RLE_RUN_W'(1) &&
                      out_word.run <= `RLE_RUN_W'(`RLE_RUN_MAX))
    ) else $error("pushed run length %0d out of range", out_word.run);

endmodule

bind run_length_encoder rle_stream_assert u_enc_assert (
    .clock    (clock),
    .rst_n    (rst_n),
    .state    (state),
    .in_empty (in_empty),
    .in_pop   (in_pop),
    .out_full (out_full),
    .out_push (out_push),
    .out_word (out_word)
);

//--- tb/rle_stream_tb.sv
// Testbench for the run-length compression subsystem with file stimulus and in-order checking
`timescale 1ns/10ps
`include "rle_stream_settings.svh"

module rle_stream_tb;

    localparam int BP_TEST   = 4;
    localparam int MAX_TESTS = 16;
    localparam int OUT_W     = 1 + `RLE_RUN_W + `RLE_BYTE_W;

    logic                   clock;
    logic                   rst_n;
    logic                   in_valid;
    logic [`RLE_BYTE_W-1:0] in_data;
    logic                   in_last;
    logic                   out_rd;
    logic                   in_full;
    logic [`RLE_RUN_W-1:0]  out_run;
    logic [`RLE_BYTE_W-1:0] out_byte;
    logic                   out_last;
    logic                   out_empty;

    // Input records as {last, byte}, expected pairs as {last, run, byte}
    logic [`RLE_BYTE_W:0] in_q[$];
    int                   in_test_q[$];
    logic [OUT_W-1:0]     exp_q[$];
    int                   exp_end[MAX_TESTS+1];
    int                   n_tests;
    int                   n_inputs;
    int                   n_expected;

    int   errors;
    int   recv_count;
    int   full_cycles;
    int   full_start;
    int   seed;
    logic loaded;
    logic bp_mode;

    rle_stream_top u_rle_stream_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .out_rd    (out_rd),
        .in_full   (in_full),
        .out_run   (out_run),
        .out_byte  (out_byte),
        .out_last  (out_last),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic load_records();
        int               fd;
        int               test_id;
        int               run_v;
        int               byte_v;
        int               last_v;
        logic [7:0]       tok;
        logic [8*128-1:0] rest;
        fd = $fopen("tb/rle_stream_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/rle_stream_input.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                void'($fgets(rest, fd));
            end else if (tok == "T") begin
                void'($fscanf(fd, "%d", test_id));
                n_tests = test_id;
                exp_end[test_id] = exp_q.size();
            end else if (tok == "I") begin
                void'($fscanf(fd, "%h %h", byte_v, last_v));
                in_q.push_back({last_v[0], byte_v[`RLE_BYTE_W-1:0]});
                in_test_q.push_back(n_tests);
            end else if (tok == "E") begin
                void'($fscanf(fd, "%h %h %h", run_v, byte_v, last_v));
                exp_q.push_back({last_v[0], run_v[`RLE_RUN_W-1:0], byte_v[`RLE_BYTE_W-1:0]});
                exp_end[n_tests] = exp_q.size();
            end else begin
                $display("The stimulus file holds a record of unknown kind");
                errors++;
            end
        end
        $fclose(fd);
        n_inputs   = in_q.size();
        n_expected = exp_q.size();
    endtask

    // Called 1 ns after a rising edge, returns at the same point
    task automatic write_byte(input logic [`RLE_BYTE_W:0] rec);
        while (in_full) begin
            in_valid = 1'b0;
            @(posedge clock);
            #1;
        end
        in_valid = 1'b1;
        in_last  = rec[`RLE_BYTE_W];
        in_data  = rec[`RLE_BYTE_W-1:0];
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_pair();
        logic [OUT_W-1:0] exp_w;
        if (exp_q.size() == 0) begin
            $display("ERR %0t: unexpected pair run=%0d byte=%h last=%b",
                     $time, out_run, out_byte, out_last);
            errors++;
        end else begin
            exp_w = exp_q.pop_front();
            if ({out_last, out_run, out_byte} !== exp_w) begin
                $display("ERR %0t: pair %0d run/byte/last expected %0d/%h/%b got %0d/%h/%b",
                         $time, recv_count, exp_w[`RLE_BYTE_W +: `RLE_RUN_W],
                         exp_w[`RLE_BYTE_W-1:0], exp_w[OUT_W-1], out_run, out_byte, out_last);
                errors++;
            end
        end
        recv_count++;
    endtask

    // Output side reads on the rising edge and checks the head at the falling edge
    initial begin
        out_rd      = 1'b0;
        seed        = 32'h3ee9;
        recv_count  = 0;
        full_cycles = 0;
        forever begin
            @(posedge clock);
            #1;
            out_rd = rst_n && !out_empty && (!bp_mode || (($random(seed) & 7) == 0));
            @(negedge clock);
            if (in_full) begin
                full_cycles++;
            end
            if (out_rd) begin
                check_pair();
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        errors   = 0;
        n_tests  = 0;
        loaded   = 1'b0;
        bp_mode  = 1'b0;
        load_records();
        loaded = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(posedge clock);
        #1;
        if (!out_empty || in_full) begin
            $display("ERR %0t: after reset out_empty=%b in_full=%b", $time, out_empty, in_full);
            errors++;
        end
        for (int t = 1; t <= n_tests; t++) begin
            bp_mode    = (t == BP_TEST);
            full_start = full_cycles;
            for (int i = 0; i < n_inputs; i++) begin
                if (in_test_q[i] == t) begin
                    write_byte(in_q[i]);
                end
            end
            // All pairs of this test drained
            wait (recv_count == exp_end[t]);
            @(posedge clock);
            #1;
            if (bp_mode && full_cycles == full_start) begin
                $display("The input FIFO never became full during back-pressure test %0d", t);
                errors++;
            end
        end
        bp_mode = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        if (recv_count != n_expected) begin
            $display("Received %0d pairs but the file expects %0d", recv_count, n_expected);
            errors++;
        end
        if (!out_empty) begin
            $display("ERR %0t: out_empty is low after all pairs were read", $time);
            errors++;
        end
        $display("Summary: %0d pairs checked, %0d expected, %0d errors",
                 recv_count, n_expected, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the input record count
    initial begin
        wait (loaded);
        repeat (40 * n_inputs + 200) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", 40 * n_inputs + 200);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb/rle_stream_input.txt
# Records: T test, I byte last, E run byte last; byte, run and last values in hex
# Several records may share one line, test 4 runs with random output back-pressure
# Test 1: mixed short runs and alternating single bytes
T 1
I 41 0 I 41 0 I 41 0 I 42 0 I 43 0 I 42 0 I 43 0 I 44 0 I 44 0 I 45 1
E 3 41 0 E 1 42 0 E 1 43 0 E 1 42 0 E 1 43 0 E 2 44 0 E 1 45 1
# Test 2: nineteen equal bytes split at the maximum run
T 2
I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0
I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 0 I 55 1
E 8 55 0 E 8 55 0 E 3 55 1
# Test 3: a last byte closes its run, an equal byte after it starts a new pair
T 3
I 66 0 I 66 0 I 66 1 I 66 0 I 66 1 I 77 1
E 3 66 1 E 2 66 1 E 1 77 1
# Test 4: long input under random back-pressure
T 4
I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0
I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0 I a0 0 I a1 0
I a2 0 I a2 0 I a2 0 I a2 0 I a2 0 I a2 0 I a2 0 I a2 0 I a2 0 I a2 1
E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0
E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0 E 1 a0 0 E 1 a1 0
E 8 a2 0 E 2 a2 1

//--- rle_stream_top.f
+incdir+common
common/rle_stream_pkg.sv
fifo/common_fifo.sv
logic/run_length_encoder.sv
logic/rle_stream_top.sv
tb/rle_stream_assert.sv
tb/rle_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/10ps --top-module rle_stream_tb \
    -f rle_stream_top.f -o rle_stream_sim > build.log 2>&1 \
    && ./obj_dir/rle_stream_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^All checks passed$" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
